// ==== include/creator_consts.svh ====
//--------------------------------------------------------------------
// Register core constants
// Bus widths, region codes, register offsets and reset values
//--------------------------------------------------------------------
`ifndef CREATOR_CONSTS_SVH
`define CREATOR_CONSTS_SVH

// Bus widths
`define CREATOR_ADDR_WIDTH      15
`define CREATOR_DATA_WIDTH      16
`define CREATOR_GPIO_WIDTH      16

// Region select, top bits of the word address
`define CREATOR_REGION_BITS     3
`define CREATOR_REGION_CONFIG   3'd0
`define CREATOR_REGION_GPIO     3'd4

// Build identifier, least significant word at offset 0
`define CREATOR_VERSION         64'h44E8_05C3_000A_0001

// 150 MHz sys clk, 3 MHz PDM clk -> ratio 50
// Decimation 150e6 / (16e3 * 50) - 1, floored
`define CREATOR_SAMPLE_RATE_RST 16'd186
`define CREATOR_GAIN_RST        16'd3

// Configuration bank offsets
`define CREATOR_CFG_SAMPLE_RATE 12'd4
`define CREATOR_CFG_GAIN        12'd5

// GPIO port offsets
`define CREATOR_GPIO_OUT        12'd0
`define CREATOR_GPIO_DIR        12'd1
`define CREATOR_GPIO_IN         12'd2

`endif

// ==== logic/creator_pkg.sv ====
//--------------------------------------------------------------------
// Register core types
// Bus vectors and the SPI frame state encoding
//--------------------------------------------------------------------
`include "creator_consts.svh"

package creator_pkg;

  // Word address on the internal bus
  typedef logic [`CREATOR_ADDR_WIDTH-1:0]  addr_t;

  // Data word on the internal bus
  typedef logic [`CREATOR_DATA_WIDTH-1:0]  data_t;

  // One bit per GPIO line
  typedef logic [`CREATOR_GPIO_WIDTH-1:0]  gpio_t;

  // Region code, top address bits
  typedef logic [`CREATOR_REGION_BITS-1:0] region_t;

  // Host SPI frame phases
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_CMD,
    SPI_WAIT,
    SPI_DATA
  } spi_state_e;

endpackage

// ==== logic/host_spi_slave.sv ====
//--------------------------------------------------------------------
// Host SPI slave
// Mode 0 frames of 16 command bits and 16 data bits, MSB first,
// turned into single-cycle reads and writes on the register bus
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "creator_consts.svh"

module host_spi_slave (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ss_i,
  input  logic               sck_i,
  input  logic               mosi_i,
  output logic               spi_miso_o,
  output creator_pkg::addr_t bus_addr_o,
  output creator_pkg::data_t bus_wdata_o,
  output logic               bus_rd_o,
  output logic               bus_wr_o,
  input  creator_pkg::data_t bus_rdata_i,
  input  logic               bus_ack_i
);
  import creator_pkg::*;

  // Pin synchronizers
  logic       sck_meta_q;
  logic       sck_sync_q;
  logic       sck_prev_q;
  logic       ss_meta_q;
  logic       ss_sync_q;
  logic       mosi_meta_q;
  logic       mosi_sync_q;

  // Frame tracking
  spi_state_e state_q;
  logic [4:0] bit_cnt_q;
  logic       cmd_read_q;

  // Shift registers
  data_t      rx_q;
  data_t      rx_next;
  data_t      tx_q;

  logic       sck_rise;
  logic       sck_fall;
  logic       cmd_last;
  logic       frame_last;
  logic       first_data;

  //------------------------------------------------------------------
  // Synchronizers and edge detection
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sck_meta_q <= 1'b0;
      sck_sync_q <= 1'b0;
      sck_prev_q <= 1'b0;
      ss_meta_q  <= 1'b1;
      ss_sync_q  <= 1'b1;
    end else begin
      sck_meta_q <= sck_i;
      sck_sync_q <= sck_meta_q;
      sck_prev_q <= sck_sync_q;
      ss_meta_q  <= ss_i;
      ss_sync_q  <= ss_meta_q;
    end
  end

  // Data pin, aligned with the synchronized clock
  always_ff @(posedge clk_i) begin
    mosi_meta_q <= mosi_i;
    mosi_sync_q <= mosi_meta_q;
  end

  assign sck_rise   = sck_sync_q & ~sck_prev_q;
  assign sck_fall   = ~sck_sync_q & sck_prev_q;

  // Bit positions within the frame
  assign cmd_last   = (bit_cnt_q == 5'(`CREATOR_DATA_WIDTH - 1));
  assign frame_last = (bit_cnt_q == 5'(2 * `CREATOR_DATA_WIDTH - 1));
  assign first_data = (bit_cnt_q == 5'(`CREATOR_DATA_WIDTH));

  // Incoming word including the bit of this edge
  assign rx_next    = {rx_q[`CREATOR_DATA_WIDTH-2:0], mosi_sync_q};

  //------------------------------------------------------------------
  // Frame FSM and bus strobes
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= SPI_IDLE;
      bit_cnt_q  <= '0;
      cmd_read_q <= 1'b0;
      bus_rd_o   <= 1'b0;
      bus_wr_o   <= 1'b0;
    end else begin
      // Strobes last one cycle
      bus_rd_o <= 1'b0;
      bus_wr_o <= 1'b0;
      if (ss_sync_q) begin
        // Deselect aborts any partial frame
        state_q   <= SPI_IDLE;
        bit_cnt_q <= '0;
      end else begin
        unique case (state_q)
          SPI_IDLE: begin
            state_q   <= SPI_CMD;
            bit_cnt_q <= '0;
          end
          SPI_CMD: begin
            if (sck_rise) begin
              bit_cnt_q <= bit_cnt_q + 5'd1;
              if (cmd_last) begin
                // Bit 15 of the command selects a read
                cmd_read_q <= rx_next[`CREATOR_DATA_WIDTH-1];
                if (rx_next[`CREATOR_DATA_WIDTH-1]) begin
                  state_q  <= SPI_WAIT;
                  bus_rd_o <= 1'b1;
                end else begin
                  state_q <= SPI_DATA;
                end
              end
            end
          end
          SPI_WAIT: begin
            // Ack always one cycle after the read strobe
            if (bus_ack_i) begin
              state_q <= SPI_DATA;
            end
          end
          SPI_DATA: begin
            if (sck_rise) begin
              bit_cnt_q <= bit_cnt_q + 5'd1;
              if (frame_last) begin
                state_q  <= SPI_IDLE;
                bus_wr_o <= ~cmd_read_q;
              end
            end
          end
          default: state_q <= SPI_IDLE;
        endcase
      end
    end
  end

  //------------------------------------------------------------------
  // Receive and transmit datapath
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sck_rise && (state_q == SPI_CMD || state_q == SPI_DATA)) begin
      rx_q <= rx_next;
    end
    // Address held from command until the end of the frame
    if (sck_rise && state_q == SPI_CMD && cmd_last) begin
      bus_addr_o <= rx_next[`CREATOR_ADDR_WIDTH-1:0];
    end
    if (sck_rise && state_q == SPI_DATA && frame_last) begin
      bus_wdata_o <= rx_next;
    end
    // Read word loaded in ack cycle, MSB first
    if (state_q == SPI_IDLE) begin
      tx_q <= '0;
    end else if (state_q == SPI_WAIT && bus_ack_i) begin
      tx_q <= bus_rdata_i;
    end else if (state_q == SPI_DATA && sck_fall && !first_data) begin
      // No shift before the first data bit is sampled
      tx_q <= {tx_q[`CREATOR_DATA_WIDTH-2:0], 1'b0};
    end
  end

  assign spi_miso_o = tx_q[`CREATOR_DATA_WIDTH-1];

endmodule

// ==== logic/peripheral_bus.sv ====
//--------------------------------------------------------------------
// Register bus decoder
// Steers strobes to two regions, returns registered data and ack
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "creator_consts.svh"

module peripheral_bus (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  creator_pkg::addr_t bus_addr_i,
  input  logic               bus_rd_i,
  input  logic               bus_wr_i,
  output creator_pkg::data_t bus_rdata_o,
  output logic               bus_ack_o,
  output logic               cfg_rd_o,
  output logic               cfg_wr_o,
  input  creator_pkg::data_t cfg_rdata_i,
  output logic               gpio_rd_o,
  output logic               gpio_wr_o,
  input  creator_pkg::data_t gpio_rdata_i
);
  import creator_pkg::*;

  region_t region;
  logic    hit_cfg;
  logic    hit_gpio;
  data_t   rdata_sel;

  // Region from top address bits
  assign region   = bus_addr_i[`CREATOR_ADDR_WIDTH-1 -: `CREATOR_REGION_BITS];
  assign hit_cfg  = (region == `CREATOR_REGION_CONFIG);
  assign hit_gpio = (region == `CREATOR_REGION_GPIO);

  // Per-target strobes
  assign cfg_rd_o  = bus_rd_i & hit_cfg;
  assign cfg_wr_o  = bus_wr_i & hit_cfg;
  assign gpio_rd_o = bus_rd_i & hit_gpio;
  assign gpio_wr_o = bus_wr_i & hit_gpio;

  // Unmapped regions read as zero
  always_comb begin
    if (cfg_rd_o) begin
      rdata_sel = cfg_rdata_i;
    end else if (gpio_rd_o) begin
      rdata_sel = gpio_rdata_i;
    end else begin
      rdata_sel = '0;
    end
  end

  //------------------------------------------------------------------
  // Ack one cycle after any strobe
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= bus_rd_i | bus_wr_i;
    end
  end

  // Read word valid with the ack
  always_ff @(posedge clk_i) begin
    if (bus_rd_i) begin
      bus_rdata_o <= rdata_sel;
    end
  end

endmodule

// ==== logic/config_regs.sv ====
//--------------------------------------------------------------------
// Configuration bank
// Version words plus microphone sample-rate and gain registers
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "creator_consts.svh"

module config_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  creator_pkg::addr_t cfg_offset_i,
  input  logic               cfg_wr_i,
  input  creator_pkg::data_t cfg_wdata_i,
  output creator_pkg::data_t cfg_rdata_o,
  output creator_pkg::data_t mic_sample_rate_o,
  output creator_pkg::data_t mic_data_gain_o
);
  import creator_pkg::*;

  // Word offset within the region
  logic [`CREATOR_ADDR_WIDTH-`CREATOR_REGION_BITS-1:0] cfg_word;
  logic [63:0]                                          version;
  data_t                                                sample_rate_q;
  data_t                                                gain_q;

  assign cfg_word = cfg_offset_i[`CREATOR_ADDR_WIDTH-`CREATOR_REGION_BITS-1:0];
  assign version  = `CREATOR_VERSION;

  //------------------------------------------------------------------
  // Writable registers
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sample_rate_q <= `CREATOR_SAMPLE_RATE_RST;
      gain_q        <= `CREATOR_GAIN_RST;
    end else if (cfg_wr_i) begin
      // Version words ignore writes
      if (cfg_word == `CREATOR_CFG_SAMPLE_RATE) begin
        sample_rate_q <= cfg_wdata_i;
      end
      if (cfg_word == `CREATOR_CFG_GAIN) begin
        gain_q <= cfg_wdata_i;
      end
    end
  end

  // Read mux
  always_comb begin
    unique case (cfg_word)
      12'd0:                    cfg_rdata_o = version[15:0];
      12'd1:                    cfg_rdata_o = version[31:16];
      12'd2:                    cfg_rdata_o = version[47:32];
      12'd3:                    cfg_rdata_o = version[63:48];
      `CREATOR_CFG_SAMPLE_RATE: cfg_rdata_o = sample_rate_q;
      `CREATOR_CFG_GAIN:        cfg_rdata_o = gain_q;
      default:                  cfg_rdata_o = '0;
    endcase
  end

  // Microphone configuration outputs
  assign mic_sample_rate_o = sample_rate_q;
  assign mic_data_gain_o   = gain_q;

endmodule

// ==== logic/gpio_port.sv ====
//--------------------------------------------------------------------
// GPIO port
// Output and direction registers, synchronized input readback
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "creator_consts.svh"

module gpio_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  creator_pkg::addr_t gpio_offset_i,
  input  logic               gpio_wr_i,
  input  creator_pkg::data_t gpio_wdata_i,
  input  creator_pkg::gpio_t gpio_in_i,
  output creator_pkg::data_t gpio_rdata_o,
  output creator_pkg::gpio_t gpio_out_o,
  output creator_pkg::gpio_t gpio_oe_o
);
  import creator_pkg::*;

  logic [`CREATOR_ADDR_WIDTH-`CREATOR_REGION_BITS-1:0] gpio_word;
  gpio_t                                                out_q;
  gpio_t                                                dir_q;
  gpio_t                                                in_meta_q;
  gpio_t                                                in_sync_q;

  assign gpio_word = gpio_offset_i[`CREATOR_ADDR_WIDTH-`CREATOR_REGION_BITS-1:0];

  //------------------------------------------------------------------
  // Output value and direction, 1 drives the pin
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (gpio_wr_i) begin
      if (gpio_word == `CREATOR_GPIO_OUT) begin
        out_q <= gpio_wdata_i;
      end
      if (gpio_word == `CREATOR_GPIO_DIR) begin
        dir_q <= gpio_wdata_i;
      end
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // Readback of all three words
  always_comb begin
    unique case (gpio_word)
      `CREATOR_GPIO_OUT: gpio_rdata_o = out_q;
      `CREATOR_GPIO_DIR: gpio_rdata_o = dir_q;
      `CREATOR_GPIO_IN:  gpio_rdata_o = in_sync_q;
      default:           gpio_rdata_o = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

// ==== logic/creator_system.sv ====
//--------------------------------------------------------------------
// Sensor-board register core, top level
// Host SPI slave, region decoder, config bank and GPIO port
//--------------------------------------------------------------------
`timescale 1ns/1ps

module creator_system (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ss_i,
  input  logic               ss1_i,
  input  logic               sck_i,
  input  logic               mosi_i,
  input  logic               nfc_miso_i,
  output logic               miso_o,
  input  creator_pkg::gpio_t gpio_in_i,
  output creator_pkg::gpio_t gpio_out_o,
  output creator_pkg::gpio_t gpio_oe_o,
  output creator_pkg::data_t mic_sample_rate_o,
  output creator_pkg::data_t mic_data_gain_o
);
  import creator_pkg::*;

  // Internal register bus
  addr_t bus_addr;
  data_t bus_wdata;
  data_t bus_rdata;
  logic  bus_rd;
  logic  bus_wr;
  logic  bus_ack;

  // Target strobes and read data
  logic  cfg_wr;
  data_t cfg_rdata;
  logic  gpio_wr;
  data_t gpio_rdata;

  logic  system_miso;

  // Board select first, then pass-through device, else idle high
  assign miso_o = !ss_i ? system_miso : (!ss1_i ? nfc_miso_i : 1'b1);

  //------------------------------------------------------------------
  // Input side
  //------------------------------------------------------------------
  host_spi_slave i_host_spi_slave (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ss_i       (ss_i),
    .sck_i      (sck_i),
    .mosi_i     (mosi_i),
    .spi_miso_o (system_miso),
    .bus_addr_o (bus_addr),
    .bus_wdata_o(bus_wdata),
    .bus_rd_o   (bus_rd),
    .bus_wr_o   (bus_wr),
    .bus_rdata_i(bus_rdata),
    .bus_ack_i  (bus_ack)
  );

  // Region decoder, read strobes only steer its own mux
  peripheral_bus i_peripheral_bus (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_addr_i  (bus_addr),
    .bus_rd_i    (bus_rd),
    .bus_wr_i    (bus_wr),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack),
    .cfg_rd_o    (),
    .cfg_wr_o    (cfg_wr),
    .cfg_rdata_i (cfg_rdata),
    .gpio_rd_o   (),
    .gpio_wr_o   (gpio_wr),
    .gpio_rdata_i(gpio_rdata)
  );

  //------------------------------------------------------------------
  // Output side
  //------------------------------------------------------------------
  config_regs i_config_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_offset_i     (bus_addr),
    .cfg_wr_i         (cfg_wr),
    .cfg_wdata_i      (bus_wdata),
    .cfg_rdata_o      (cfg_rdata),
    .mic_sample_rate_o(mic_sample_rate_o),
    .mic_data_gain_o  (mic_data_gain_o)
  );

  gpio_port i_gpio_port (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .gpio_offset_i(bus_addr),
    .gpio_wr_i    (gpio_wr),
    .gpio_wdata_i (bus_wdata),
    .gpio_in_i    (gpio_in_i),
    .gpio_rdata_o (gpio_rdata),
    .gpio_out_o   (gpio_out_o),
    .gpio_oe_o    (gpio_oe_o)
  );

endmodule

// ==== testbench/creator_properties.sv ====
//--------------------------------------------------------------------
// Register bus protocol checks
// Bound to the decoder, strobe exclusivity and ack timing
//--------------------------------------------------------------------
`timescale 1ns/1ps

module creator_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic bus_rd_i,
  input logic bus_wr_i,
  input logic bus_ack_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Read and write never together
  a_strobe_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(bus_rd_i && bus_wr_i)
  ) else begin
    fail_count = fail_count + 1;
    $error("Read and write strobes were high in the same cycle");
  end

  // Ack one cycle after each strobe
  a_ack_follows: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (bus_rd_i || bus_wr_i) |=> bus_ack_i
  ) else begin
    fail_count = fail_count + 1;
    $error("Bus ack did not follow a strobe by one cycle");
  end

  // No ack without a strobe before it
  a_ack_needs_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) bus_ack_i |-> $past(bus_rd_i || bus_wr_i)
  ) else begin
    fail_count = fail_count + 1;
    $error("Bus ack was high without a strobe in the previous cycle");
  end

endmodule

bind peripheral_bus creator_properties i_creator_properties (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .bus_rd_i (bus_rd_i),
  .bus_wr_i (bus_wr_i),
  .bus_ack_i(bus_ack_o)
);

// ==== testbench/tb_creator_system.sv ====
//--------------------------------------------------------------------
// Register core testbench
// Host SPI frames against a register-map model, port and miso checks
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "creator_consts.svh"

module tb_creator_system;
  import creator_pkg::*;

  // SCK half period in clk cycles
  localparam int half_period  = 10;
  // 32 bits plus select setup and gap
  localparam int frame_cycles = 2 * half_period * 32 + 4 * half_period;
  localparam int num_rounds   = 4;
  // Frames of the sequence below, plus a quarter margin
  localparam int test_frames  = 6 + 8 + 8 * num_rounds + 2 + 2;
  localparam int cycle_limit  = test_frames * frame_cycles * 5 / 4;

  logic  clk_i;
  logic  rst_n_i;
  logic  ss_i;
  logic  ss1_i;
  logic  sck_i;
  logic  mosi_i;
  logic  nfc_miso_i;
  logic  miso_o;
  gpio_t gpio_in_i;
  gpio_t gpio_out_o;
  gpio_t gpio_oe_o;
  data_t mic_sample_rate_o;
  data_t mic_data_gain_o;

  // Register map model
  data_t  model_rate;
  data_t  model_gain;
  gpio_t  model_out;
  gpio_t  model_dir;
  gpio_t  model_in;

  integer seed;
  int     cycle_count;
  int     check_count;
  int     error_count;

  // Read results waiting for comparison
  addr_t  addr_q[$];
  data_t  got_q[$];
  data_t  exp_q[$];

  creator_system i_creator_system (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ss_i             (ss_i),
    .ss1_i            (ss1_i),
    .sck_i            (sck_i),
    .mosi_i           (mosi_i),
    .nfc_miso_i       (nfc_miso_i),
    .miso_o           (miso_o),
    .gpio_in_i        (gpio_in_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_oe_o        (gpio_oe_o),
    .mic_sample_rate_o(mic_sample_rate_o),
    .mic_data_gain_o  (mic_data_gain_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic data_t rand_word();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic addr_t make_addr(input region_t region, input logic [11:0] offset);
    return {region, offset};
  endfunction

  // Expected read word from the model
  function automatic data_t ref_read(input addr_t addr);
    logic [63:0] version;
    region_t     region;
    logic [11:0] word;
    data_t       value;
    version = `CREATOR_VERSION;
    region  = addr[14:12];
    word    = addr[11:0];
    value   = '0;
    if (region == `CREATOR_REGION_CONFIG) begin
      // Four version words, low word first
      if (word < 12'd4) begin
        value = version[16*word +: 16];
      end else if (word == `CREATOR_CFG_SAMPLE_RATE) begin
        value = model_rate;
      end else if (word == `CREATOR_CFG_GAIN) begin
        value = model_gain;
      end
    end else if (region == `CREATOR_REGION_GPIO) begin
      if (word == `CREATOR_GPIO_OUT) begin
        value = model_out;
      end else if (word == `CREATOR_GPIO_DIR) begin
        value = model_dir;
      end else if (word == `CREATOR_GPIO_IN) begin
        value = model_in;
      end
    end
    return value;
  endfunction

  // Model update, read-only and unmapped words ignore writes
  task automatic apply_write(input addr_t addr, input data_t data);
    if (addr[14:12] == `CREATOR_REGION_CONFIG) begin
      if (addr[11:0] == `CREATOR_CFG_SAMPLE_RATE) model_rate = data;
      if (addr[11:0] == `CREATOR_CFG_GAIN) model_gain = data;
    end else if (addr[14:12] == `CREATOR_REGION_GPIO) begin
      if (addr[11:0] == `CREATOR_GPIO_OUT) model_out = data;
      if (addr[11:0] == `CREATOR_GPIO_DIR) model_dir = data;
    end
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // One mode 0 frame, miso sampled on rising SCK of the data half
  task automatic shift_frame(input logic [31:0] frame, output data_t rx);
    int i;
    rx = '0;
    @(negedge clk_i);
    ss_i = 1'b0;
    for (i = 31; i >= 0; i--) begin
      mosi_i = frame[i];
      repeat (half_period) @(negedge clk_i);
      sck_i = 1'b1;
      if (i < 16) begin
        rx = {rx[14:0], miso_o};
      end
      repeat (half_period) @(negedge clk_i);
      sck_i = 1'b0;
    end
    repeat (half_period) @(negedge clk_i);
    ss_i = 1'b1;
    repeat (2 * half_period) @(negedge clk_i);
  endtask

  task automatic spi_write(input addr_t addr, input data_t data);
    data_t unused_rx;
    shift_frame({1'b0, addr, data}, unused_rx);
    apply_write(addr, data);
  endtask

  task automatic spi_read(input addr_t addr);
    data_t rx;
    shift_frame({1'b1, addr, 16'h0000}, rx);
    addr_q.push_back(addr);
    got_q.push_back(rx);
    exp_q.push_back(ref_read(addr));
  endtask

  //------------------------------------------------------------------
  // Compare and timeout
  //------------------------------------------------------------------
  always @(negedge clk_i) begin
    addr_t a;
    data_t g;
    data_t e;
    if (got_q.size() > 0) begin
      a = addr_q.pop_front();
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_value($sformatf("miso_o word at %h", a), g, e);
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  //------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------
  initial begin
    data_t v;
    logic  nfc_bit;
    int    i;
    int    assert_fails;
    seed        = 32'h3356;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    rst_n_i     = 1'b0;
    ss_i        = 1'b1;
    ss1_i       = 1'b1;
    sck_i       = 1'b0;
    mosi_i      = 1'b0;
    nfc_miso_i  = 1'b0;
    gpio_in_i   = '0;
    model_rate  = `CREATOR_SAMPLE_RATE_RST;
    model_gain  = `CREATOR_GAIN_RST;
    model_out   = '0;
    model_dir   = '0;
    model_in    = '0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);

    // Reset state
    check_value("miso_o idle", {15'b0, miso_o}, 16'h0001);
    check_value("gpio_out_o", gpio_out_o, '0);
    check_value("gpio_oe_o", gpio_oe_o, '0);
    for (i = 0; i < 6; i++) begin
      spi_read(make_addr(`CREATOR_REGION_CONFIG, 12'(i)));
    end
    check_value("mic_sample_rate_o", mic_sample_rate_o, 16'd186);
    check_value("mic_data_gain_o", mic_data_gain_o, 16'd3);

    // Sample rate and gain
    for (i = 0; i < num_rounds; i++) begin
      spi_write(make_addr(`CREATOR_REGION_CONFIG, `CREATOR_CFG_SAMPLE_RATE), rand_word());
      spi_write(make_addr(`CREATOR_REGION_CONFIG, `CREATOR_CFG_GAIN), rand_word());
      spi_read(make_addr(`CREATOR_REGION_CONFIG, `CREATOR_CFG_SAMPLE_RATE));
      spi_read(make_addr(`CREATOR_REGION_CONFIG, `CREATOR_CFG_GAIN));
      check_value("mic_sample_rate_o", mic_sample_rate_o, model_rate);
      check_value("mic_data_gain_o", mic_data_gain_o, model_gain);
    end

    // Version words stay read only
    for (i = 0; i < 4; i++) begin
      spi_write(make_addr(`CREATOR_REGION_CONFIG, 12'(i)), rand_word());
    end
    for (i = 0; i < 4; i++) begin
      spi_read(make_addr(`CREATOR_REGION_CONFIG, 12'(i)));
    end

    // GPIO output and direction
    for (i = 0; i < num_rounds; i++) begin
      spi_write(make_addr(`CREATOR_REGION_GPIO, `CREATOR_GPIO_OUT), rand_word());
      spi_write(make_addr(`CREATOR_REGION_GPIO, `CREATOR_GPIO_DIR), rand_word());
      check_value("gpio_out_o", gpio_out_o, model_out);
      check_value("gpio_oe_o", gpio_oe_o, model_dir);
      spi_read(make_addr(`CREATOR_REGION_GPIO, `CREATOR_GPIO_OUT));
      spi_read(make_addr(`CREATOR_REGION_GPIO, `CREATOR_GPIO_DIR));
    end

    // GPIO input through the synchronizer
    for (i = 0; i < 2; i++) begin
      v         = rand_word();
      gpio_in_i = v;
      model_in  = v;
      repeat (4) @(negedge clk_i);
      spi_read(make_addr(`CREATOR_REGION_GPIO, `CREATOR_GPIO_IN));
    end

    // Unmapped regions
    spi_read(15'h2000);
    spi_read(15'h7fff);

    // Pass-through device on the second select
    ss1_i   = 1'b0;
    nfc_bit = 1'b0;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_i);
      nfc_bit    = ~nfc_bit;
      nfc_miso_i = nfc_bit;
      @(posedge clk_i);
      check_value("miso_o from nfc_miso_i", {15'b0, miso_o}, {15'b0, nfc_bit});
    end
    @(negedge clk_i);
    ss1_i = 1'b1;
    @(posedge clk_i);
    check_value("miso_o idle", {15'b0, miso_o}, 16'h0001);

    // Let the compare process drain
    while (got_q.size() > 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);

    assert_fails = int'(i_creator_system.i_peripheral_bus.i_creator_properties.fail_count);
    $display("Checks %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
logic/creator_pkg.sv
logic/host_spi_slave.sv
logic/peripheral_bus.sv
logic/config_regs.sv
logic/gpio_port.sv
logic/creator_system.sv
testbench/creator_properties.sv
testbench/tb_creator_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the register core testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f \
  --top-module tb_creator_system -Mdir obj_dir -o sim_tb

# Keep going to the log search even if the model stops early
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qF '** PASS **' sim.log; then
  exit 0
else
  exit 1
fi
